//--- verilog/mipsCfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Datapath and register index widths
`define XLEN 32
`define REG_ADDR_W 5

// Instruction memory, word addressed
`define IMEM_WORDS 64
`define IMEM_AW $clog2(`IMEM_WORDS)

// Data memory, word addressed by address bits above [1:0]
`define DMEM_WORDS 64
`define DMEM_AW $clog2(`DMEM_WORDS)

`endif

//--- verilog/mipsPkg.sv
package mipsPkg;

	// Primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'd0,
		OP_J = 6'd2,
		OP_BEQ = 6'd4,
		OP_BNE = 6'd5,
		OP_ADDI = 6'd8,
		OP_ADDIU = 6'd9,
		OP_SLTI = 6'd10,
		OP_ANDI = 6'd12,
		OP_ORI = 6'd13,
		OP_XORI = 6'd14,
		OP_LW = 6'd35,
		OP_SW = 6'd43
	} opcodeE;

	// Function field of SPECIAL, instr[5:0]
	typedef enum logic [5:0] {
		FN_ADD = 6'd32,
		FN_ADDU = 6'd33,
		FN_SUB = 6'd34,
		FN_SUBU = 6'd35,
		FN_AND = 6'd36,
		FN_OR = 6'd37,
		FN_XOR = 6'd38,
		FN_NOR = 6'd39,
		FN_SLT = 6'd42
	} functE;

	typedef enum logic [2:0] {ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_ADD, ALU_SUB, ALU_SLT} aluOpE;

	typedef enum logic {WB_ALU, WB_MEM} wbSrcE;

endpackage

//--- verilog/fetchStage.sv
`timescale 1ns/1ps
`include "mipsCfg.svh"

module fetchStage (
	input logic Clk,
	input logic rstN,
	input logic imemWrEn,
	input logic [`IMEM_AW-1:0] imemAddr,
	input logic [`XLEN-1:0] imemData,
	input logic branchTaken,
	input logic [`XLEN-1:0] branchTarget,
	input logic jumpTaken,
	input logic [`XLEN-1:0] jumpTarget,
	output logic [`XLEN-1:0] instrId,
	output logic [`XLEN-1:0] pcId
);

	logic [`XLEN-1:0] imem [`IMEM_WORDS];
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] pcNext;
	logic [`XLEN-1:0] instrIf;

	// Program load port
	always_ff @(posedge Clk) begin
		if (imemWrEn)
			imem[imemAddr] <= imemData;
	end

	assign instrIf = imem[pc[`IMEM_AW+1:2]]; // Word fetch at PC

	// Branch is older than the jump in decode, so it wins
	always_comb begin
		if (branchTaken)
			pcNext = branchTarget;
		else if (jumpTaken)
			pcNext = jumpTarget;
		else
			pcNext = pc + `XLEN'd4;
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			instrId <= '0;
		end else begin
			pc <= pcNext;
			if (branchTaken || jumpTaken)
				instrId <= '0; // Squash into a bubble
			else
				instrId <= instrIf;
		end
	end

	always_ff @(posedge Clk) begin
		pcId <= pc;
	end

endmodule

//--- verilog/decodeStage.sv
`timescale 1ns/1ps
`include "mipsCfg.svh"

module decodeStage (
	input logic Clk,
	input logic rstN,
	input logic [`XLEN-1:0] instrId,
	input logic [`XLEN-1:0] pcId,
	input logic [`XLEN-1:0] rsData,
	input logic [`XLEN-1:0] rtData,
	output logic [`REG_ADDR_W-1:0] rsIdx,
	output logic [`REG_ADDR_W-1:0] rtIdx,
	output logic jumpTaken,
	output logic [`XLEN-1:0] jumpTarget,
	output mipsPkg::aluOpE aluOpEx,
	output logic aluSrcImmEx,
	output logic memReadEx,
	output logic memWriteEx,
	output mipsPkg::wbSrcE wbSrcEx,
	output logic regWriteEx,
	output logic [`REG_ADDR_W-1:0] destRegEx,
	output logic [`REG_ADDR_W-1:0] rsEx,
	output logic [`REG_ADDR_W-1:0] rtEx,
	output logic [`XLEN-1:0] rsDataEx,
	output logic [`XLEN-1:0] rtDataEx,
	output logic [`XLEN-1:0] immEx,
	output logic [`XLEN-1:0] pcEx,
	output logic branchEqEx,
	output logic branchNeEx
);
	import mipsPkg::*;

	opcodeE opcode;
	functE funct;
	aluOpE aluOp;
	wbSrcE wbSrc;
	logic aluSrcImm, memRead, memWrite, regWrite, regDstRd;
	logic branchEq, branchNe, zeroExt;
	logic [`REG_ADDR_W-1:0] destReg;
	logic [`XLEN-1:0] imm;

	assign opcode = opcodeE'(instrId[31:26]);
	assign funct = functE'(instrId[5:0]);
	assign rsIdx = instrId[25:21];
	assign rtIdx = instrId[20:16];

	// Anything not listed falls through as a bubble
	always_comb begin
		aluOp = ALU_ADD;
		aluSrcImm = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		wbSrc = WB_ALU;
		regWrite = 1'b0;
		regDstRd = 1'b0;
		branchEq = 1'b0;
		branchNe = 1'b0;
		zeroExt = 1'b0;
		jumpTaken = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				regDstRd = 1'b1;
				regWrite = 1'b1;
				case (funct)
					FN_ADD, FN_ADDU: aluOp = ALU_ADD;
					FN_SUB, FN_SUBU: aluOp = ALU_SUB;
					FN_AND: aluOp = ALU_AND;
					FN_OR: aluOp = ALU_OR;
					FN_XOR: aluOp = ALU_XOR;
					FN_NOR: aluOp = ALU_NOR;
					FN_SLT: aluOp = ALU_SLT;
					default: regWrite = 1'b0; // Includes the all-zero word
				endcase
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI: begin
				aluSrcImm = 1'b1;
				regWrite = 1'b1;
				zeroExt = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
				case (opcode)
					OP_SLTI: aluOp = ALU_SLT;
					OP_ANDI: aluOp = ALU_AND;
					OP_ORI: aluOp = ALU_OR;
					OP_XORI: aluOp = ALU_XOR;
					default: aluOp = ALU_ADD;
				endcase
			end
			OP_LW: begin
				aluSrcImm = 1'b1;
				memRead = 1'b1;
				wbSrc = WB_MEM;
				regWrite = 1'b1;
			end
			OP_SW: begin
				aluSrcImm = 1'b1;
				memWrite = 1'b1;
			end
			OP_BEQ: begin
				aluOp = ALU_SUB;
				branchEq = 1'b1;
			end
			OP_BNE: begin
				aluOp = ALU_SUB;
				branchNe = 1'b1;
			end
			OP_J: jumpTaken = 1'b1;
			default: ;
		endcase
	end

	assign destReg = regDstRd ? instrId[15:11] : instrId[20:16];
	assign imm = {{(`XLEN-16){instrId[15] & ~zeroExt}}, instrId[15:0]};
	assign jumpTarget = {pcId[`XLEN-1:`XLEN-4], instrId[25:0], 2'b00};

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			aluOpEx <= ALU_ADD;
			aluSrcImmEx <= 1'b0;
			memReadEx <= 1'b0;
			memWriteEx <= 1'b0;
			wbSrcEx <= WB_ALU;
			regWriteEx <= 1'b0;
			branchEqEx <= 1'b0;
			branchNeEx <= 1'b0;
		end else begin
			aluOpEx <= aluOp;
			aluSrcImmEx <= aluSrcImm;
			memReadEx <= memRead;
			memWriteEx <= memWrite;
			wbSrcEx <= wbSrc;
			regWriteEx <= regWrite;
			branchEqEx <= branchEq;
			branchNeEx <= branchNe;
		end
	end

	always_ff @(posedge Clk) begin
		destRegEx <= destReg;
		rsEx <= rsIdx;
		rtEx <= rtIdx;
		rsDataEx <= rsData;
		rtDataEx <= rtData;
		immEx <= imm;
		pcEx <= pcId;
	end

endmodule

//--- verilog/registerFile.sv
`timescale 1ns/1ps
`include "mipsCfg.svh"

module registerFile (
	input logic Clk,
	input logic rstN,
	input logic [`REG_ADDR_W-1:0] rsIdx,
	input logic [`REG_ADDR_W-1:0] rtIdx,
	input logic wbEn,
	input logic [`REG_ADDR_W-1:0] wbReg,
	input logic [`XLEN-1:0] wbData,
	output logic [`XLEN-1:0] rsData,
	output logic [`XLEN-1:0] rtData
);

	logic [`XLEN-1:0] regs [2**`REG_ADDR_W];

	// Same-cycle write is visible to the reader
	function automatic logic [`XLEN-1:0] readPort(input logic [`REG_ADDR_W-1:0] idx);
		if (wbEn && wbReg != '0 && wbReg == idx)
			return wbData;
		return regs[idx];
	endfunction

	always_comb begin
		rsData = readPort(rsIdx);
		rtData = readPort(rtIdx);
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 2**`REG_ADDR_W; i++)
				regs[i] <= '0;
		end else if (wbEn && wbReg != '0) begin // r0 stays zero
			regs[wbReg] <= wbData;
		end
	end

endmodule

//--- verilog/executeStage.sv
`timescale 1ns/1ps
`include "mipsCfg.svh"

module executeStage (
	input logic Clk,
	input logic rstN,
	input mipsPkg::aluOpE aluOpEx,
	input logic aluSrcImmEx,
	input logic memReadEx,
	input logic memWriteEx,
	input mipsPkg::wbSrcE wbSrcEx,
	input logic regWriteEx,
	input logic [`REG_ADDR_W-1:0] destRegEx,
	input logic [`REG_ADDR_W-1:0] rsEx,
	input logic [`REG_ADDR_W-1:0] rtEx,
	input logic [`XLEN-1:0] rsDataEx,
	input logic [`XLEN-1:0] rtDataEx,
	input logic [`XLEN-1:0] immEx,
	input logic [`XLEN-1:0] pcEx,
	input logic branchEqEx,
	input logic branchNeEx,
	input logic [`XLEN-1:0] fwdDataMem,
	input logic wbEn,
	input logic [`REG_ADDR_W-1:0] wbReg,
	input logic [`XLEN-1:0] wbData,
	output logic branchTaken,
	output logic [`XLEN-1:0] branchTarget,
	output logic [`XLEN-1:0] aluResultMem,
	output logic [`XLEN-1:0] storeDataMem,
	output logic memReadMem,
	output logic memWriteMem,
	output mipsPkg::wbSrcE wbSrcMem,
	output logic regWriteMem,
	output logic [`REG_ADDR_W-1:0] destRegMem
);
	import mipsPkg::*;

	logic [`XLEN-1:0] opA, rtFwd, opB, aluResult;

	// Youngest producer first: MEM, then WB, then register value
	function automatic logic [`XLEN-1:0] fwdOperand(
		input logic [`REG_ADDR_W-1:0] src,
		input logic [`XLEN-1:0] regVal
	);
		if (regWriteMem && destRegMem != '0 && destRegMem == src)
			return fwdDataMem;
		if (wbEn && wbReg != '0 && wbReg == src)
			return wbData;
		return regVal;
	endfunction

	always_comb begin
		opA = fwdOperand(rsEx, rsDataEx);
		rtFwd = fwdOperand(rtEx, rtDataEx);
	end

	assign opB = aluSrcImmEx ? immEx : rtFwd;

	always_comb begin
		case (aluOpEx)
			ALU_AND: aluResult = opA & opB;
			ALU_OR: aluResult = opA | opB;
			ALU_XOR: aluResult = opA ^ opB;
			ALU_NOR: aluResult = ~(opA | opB);
			ALU_ADD: aluResult = opA + opB;
			ALU_SUB: aluResult = opA - opB;
			ALU_SLT: aluResult = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			default: aluResult = '0;
		endcase
	end

	// Compare uses forwarded rs and rt
	assign branchTaken = (branchEqEx && opA == rtFwd) || (branchNeEx && opA != rtFwd);
	assign branchTarget = pcEx + (immEx << 2);

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			memReadMem <= 1'b0;
			memWriteMem <= 1'b0;
			wbSrcMem <= WB_ALU;
			regWriteMem <= 1'b0;
		end else begin
			memReadMem <= memReadEx;
			memWriteMem <= memWriteEx;
			wbSrcMem <= wbSrcEx;
			regWriteMem <= regWriteEx;
		end
	end

	always_ff @(posedge Clk) begin
		aluResultMem <= aluResult;
		storeDataMem <= rtFwd;
		destRegMem <= destRegEx;
	end

endmodule

//--- verilog/memoryStage.sv
`timescale 1ns/1ps
`include "mipsCfg.svh"

module memoryStage (
	input logic Clk,
	input logic rstN,
	input logic [`XLEN-1:0] aluResultMem,
	input logic [`XLEN-1:0] storeDataMem,
	input logic memReadMem,
	input logic memWriteMem,
	input mipsPkg::wbSrcE wbSrcMem,
	input logic regWriteMem,
	input logic [`REG_ADDR_W-1:0] destRegMem,
	output logic [`XLEN-1:0] fwdDataMem,
	output logic wbEn,
	output logic [`REG_ADDR_W-1:0] wbReg,
	output logic [`XLEN-1:0] wbData
);
	import mipsPkg::*;

	logic [`XLEN-1:0] dmem [`DMEM_WORDS];
	logic [`DMEM_AW-1:0] dmemIdx;
	logic [`XLEN-1:0] loadData;

	assign dmemIdx = aluResultMem[`DMEM_AW+1:2];

	always_ff @(posedge Clk) begin
		if (memWriteMem)
			dmem[dmemIdx] <= storeDataMem;
	end

	// Combinational read so a load can forward into execute
	assign loadData = memReadMem ? dmem[dmemIdx] : '0;
	assign fwdDataMem = (wbSrcMem == WB_MEM) ? loadData : aluResultMem;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			wbEn <= 1'b0;
		else
			wbEn <= regWriteMem;
	end

	always_ff @(posedge Clk) begin
		wbReg <= destRegMem;
		wbData <= fwdDataMem;
	end

endmodule

//--- verilog/mipsPipeline.sv
`timescale 1ns/1ps
`include "mipsCfg.svh"

module mipsPipeline (
	input logic Clk,
	input logic rstN,
	input logic imemWrEn,
	input logic [`IMEM_AW-1:0] imemAddr,
	input logic [`XLEN-1:0] imemData,
	output logic wbEn,
	output logic [`REG_ADDR_W-1:0] wbReg,
	output logic [`XLEN-1:0] wbData
);
	import mipsPkg::*;

	// Fetch and decode
	logic [`XLEN-1:0] instrId, pcId;
	logic jumpTaken, branchTaken;
	logic [`XLEN-1:0] jumpTarget, branchTarget;
	logic [`REG_ADDR_W-1:0] rsIdx, rtIdx;
	logic [`XLEN-1:0] rsData, rtData;

	// ID/EX
	aluOpE aluOpEx;
	wbSrcE wbSrcEx;
	logic aluSrcImmEx, memReadEx, memWriteEx, regWriteEx;
	logic branchEqEx, branchNeEx;
	logic [`REG_ADDR_W-1:0] destRegEx, rsEx, rtEx;
	logic [`XLEN-1:0] rsDataEx, rtDataEx, immEx, pcEx;

	// EX/MEM
	wbSrcE wbSrcMem;
	logic memReadMem, memWriteMem, regWriteMem;
	logic [`REG_ADDR_W-1:0] destRegMem;
	logic [`XLEN-1:0] aluResultMem, storeDataMem, fwdDataMem;

	fetchStage fetch0 (.*);

	decodeStage decode0 (.*);

	registerFile regFile0 (.*);

	executeStage execute0 (.*);

	memoryStage memory0 (.*);

endmodule

//--- tests/mipsPipelineTb.sv
`timescale 1ns/1ps
`include "mipsCfg.svh"

module mipsPipelineTb;
	import mipsPkg::*;

	localparam int clkPeriod = 40;
	localparam int resetCycles = 16;
	localparam int maxWaitCycles = 200;
	localparam int imemAw = `IMEM_AW;

	logic Clk;
	logic rstN;
	logic imemWrEn;
	logic [`IMEM_AW-1:0] imemAddr;
	logic [`XLEN-1:0] imemData;
	logic wbEn;
	logic [`REG_ADDR_W-1:0] wbReg;
	logic [`XLEN-1:0] wbData;

	logic [31:0] rngState;
	logic [31:0] prog [$];
	logic [`REG_ADDR_W-1:0] expReg [$];
	logic [`REG_ADDR_W-1:0] gotReg [$];
	logic [`XLEN-1:0] expData [$];
	logic [`XLEN-1:0] gotData [$];
	logic [`XLEN-1:0] modelDmem [`DMEM_WORDS]; // Persists across resets like the DUT memory

	mipsPipeline dut0 (.*);

	initial begin
		Clk = 1'b0;
		forever #(clkPeriod / 2) Clk = ~Clk;
	end

	// Writeback port is stable at the falling edge
	always @(negedge Clk) begin
		if (wbEn && wbReg != '0) begin
			gotReg.push_back(wbReg);
			gotData.push_back(wbData);
		end
	end

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic int randomSrc();
		return 1 + int'(nextRandom() % 32'd8);
	endfunction

	task automatic emitImm(input opcodeE op, input int rt, input int rs, input int imm);
		prog.push_back({op, 5'(rs), 5'(rt), 16'(imm)});
	endtask

	task automatic emitReg(input functE fn, input int rd, input int rs, input int rt);
		prog.push_back({6'd0, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn});
	endtask

	task automatic emitJump(input int index);
		prog.push_back({OP_J, 26'(index)});
	endtask

	// J to itself parks the core, then one defined word behind it
	task automatic appendHalt();
		emitJump(prog.size());
		prog.push_back('0);
	endtask

	task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("FAIL %0t ns: %s got 0x%08h expected 0x%08h", $time, what, actual, expected);
			$display("TESTBENCH FAILED");
			$fatal(1, "Mismatch in %s", what);
		end
	endtask

	// Sequential ISA model, one delay slot after branches, none after J
	task automatic runModel();
		logic [31:0] regs [32];
		logic [31:0] pc, newPc, slotTarget, ins, a, b, imm, res, addr;
		logic [`REG_ADDR_W-1:0] dst;
		logic wr, slotPending, branchNow, halted;
		int idx, steps;
		foreach (regs[i])
			regs[i] = '0;
		expReg.delete();
		expData.delete();
		pc = '0;
		slotPending = 1'b0;
		slotTarget = '0;
		halted = 1'b0;
		steps = 0;
		while (!halted && steps < 400) begin
			idx = int'(pc >> 2);
			ins = (idx < prog.size()) ? prog[idx] : '0;
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			addr = a + imm;
			dst = ins[20:16];
			res = '0;
			wr = 1'b1;
			branchNow = 1'b0;
			newPc = pc + 32'd4;
			case (ins[31:26])
				OP_SPECIAL: begin
					dst = ins[15:11];
					case (ins[5:0])
						FN_ADD, FN_ADDU: res = a + b;
						FN_SUB, FN_SUBU: res = a - b;
						FN_AND: res = a & b;
						FN_OR: res = a | b;
						FN_XOR: res = a ^ b;
						FN_NOR: res = ~(a | b);
						FN_SLT: res = {31'd0, $signed(a) < $signed(b)};
						default: wr = 1'b0;
					endcase
				end
				OP_ADDI, OP_ADDIU: res = a + imm;
				OP_SLTI: res = {31'd0, $signed(a) < $signed(imm)};
				OP_ANDI: res = a & {16'd0, ins[15:0]};
				OP_ORI: res = a | {16'd0, ins[15:0]};
				OP_XORI: res = a ^ {16'd0, ins[15:0]};
				OP_LW: res = modelDmem[addr[`DMEM_AW+1:2]];
				OP_SW: begin
					wr = 1'b0;
					modelDmem[addr[`DMEM_AW+1:2]] = b;
				end
				OP_BEQ: begin
					wr = 1'b0;
					branchNow = (a == b);
				end
				OP_BNE: begin
					wr = 1'b0;
					branchNow = (a != b);
				end
				OP_J: begin
					wr = 1'b0;
					newPc = {pc[31:28], ins[25:0], 2'b00};
					halted = (newPc == pc);
				end
				default: wr = 1'b0; // Unsupported, a bubble
			endcase
			if (wr && dst != '0) begin
				regs[dst] = res;
				expReg.push_back(dst);
				expData.push_back(res);
			end
			if (slotPending)
				newPc = slotTarget; // This was the delay slot
			slotPending = branchNow;
			slotTarget = pc + (imm << 2);
			pc = newPc;
			steps++;
		end
	endtask

	task automatic runAndCheck(input string name);
		int loadCycles;
		int waited;
		loadCycles = (prog.size() > resetCycles) ? prog.size() : resetCycles;
		@(posedge Clk);
		#2;
		rstN = 1'b0;
		gotReg.delete();
		gotData.delete();
		for (int i = 0; i < loadCycles; i++) begin
			imemWrEn = (i < prog.size());
			imemAddr = imemAw'(i);
			imemData = (i < prog.size()) ? prog[i] : '0;
			@(posedge Clk);
			#2;
		end
		imemWrEn = 1'b0;
		runModel();
		rstN = 1'b1;
		waited = 0;
		while (gotReg.size() < expReg.size() && waited < maxWaitCycles) begin
			@(posedge Clk);
			waited++;
		end
		if (gotReg.size() < expReg.size()) begin
			$display("Timed out in the %s test: %0d of %0d register writes seen after %0d cycles",
				name, gotReg.size(), expReg.size(), waited);
			$display("TESTBENCH FAILED");
			$fatal(1, "Timeout in %s", name);
		end
		repeat (8) @(posedge Clk); // Room for stray writes
		foreach (expReg[k]) begin
			checkEqual(32'(gotReg[k]), 32'(expReg[k]), $sformatf("%s write %0d reg", name, k));
			checkEqual(gotData[k], expData[k], $sformatf("%s write %0d data", name, k));
		end
		checkEqual(32'(gotReg.size()), 32'(expReg.size()), {name, " write count"});
	endtask

	task automatic testAluOps();
		functE fns [9];
		opcodeE ops [6];
		fns = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT};
		ops = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI};
		prog.delete();
		for (int r = 1; r <= 8; r++)
			emitImm(OP_ADDI, r, 0, int'(nextRandom()));
		foreach (fns[k])
			emitReg(fns[k], 9 + k, randomSrc(), randomSrc());
		// Top immediate bit set except for ADDIU, so zero and sign extension differ
		foreach (ops[k])
			emitImm(ops[k], 18 + k, randomSrc(), int'(nextRandom() & 32'h7fff) | (k == 1 ? 0 : 'h8000));
		appendHalt();
		runAndCheck("alu");
	endtask

	task automatic testForwarding();
		prog.delete();
		emitImm(OP_ADDI, 1, 0, int'(nextRandom()));
		emitImm(OP_ADDI, 2, 0, int'(nextRandom()));
		emitReg(FN_ADD, 3, 1, 2); // Distance one and two
		emitReg(FN_SUB, 4, 3, 1);
		emitReg(FN_ADD, 5, 4, 3);
		emitReg(FN_SUB, 6, 5, 3); // r3 at distance three
		emitReg(FN_ADD, 1, 1, 1);
		emitReg(FN_ADD, 1, 1, 1);
		emitReg(FN_SUB, 7, 1, 6);
		emitImm(OP_ADDI, 8, 0, 5);
		emitImm(OP_ADDI, 8, 0, 9); // Younger producer wins
		emitReg(FN_ADD, 9, 8, 8);
		emitReg(FN_SUB, 10, 9, 2);
		appendHalt();
		runAndCheck("forwarding");
	endtask

	task automatic testMemory();
		prog.delete();
		for (int r = 1; r <= 4; r++)
			emitImm(OP_ADDI, r, 0, int'(nextRandom()));
		emitImm(OP_SW, 1, 0, 'h00);
		emitImm(OP_SW, 2, 0, 'h24);
		emitImm(OP_SW, 3, 0, 'h80);
		emitImm(OP_SW, 4, 0, 'hfc);
		emitImm(OP_ADDI, 5, 0, 'h40);
		emitImm(OP_SW, 2, 5, 8);
		emitImm(OP_ADDI, 6, 0, int'(nextRandom()));
		emitImm(OP_SW, 6, 0, 'h50); // Store data straight from the ADDI
		emitImm(OP_LW, 10, 0, 'h00);
		emitImm(OP_LW, 11, 0, 'h24);
		emitReg(FN_ADD, 12, 11, 10); // Load result used at once
		emitImm(OP_LW, 13, 0, 'h80);
		emitImm(OP_LW, 14, 0, 'hfc);
		emitImm(OP_LW, 15, 5, 8);
		emitReg(FN_ADD, 16, 15, 14);
		emitImm(OP_LW, 17, 0, 'h50);
		emitImm(OP_SW, 16, 0, 'h30);
		emitImm(OP_LW, 18, 0, 'h30);
		emitImm(OP_ADDI, 19, 18, 1);
		appendHalt();
		runAndCheck("memory");
	endtask

	task automatic testBranches();
		prog.delete();
		emitImm(OP_ADDI, 1, 0, 5);
		emitImm(OP_ADDI, 2, 0, 5);
		emitImm(OP_ADDI, 3, 0, 7);
		emitImm(OP_BEQ, 2, 1, 4); // Word 3, taken to word 7
		emitImm(OP_ADDI, 4, 0, 'h11); // Delay slot
		emitImm(OP_ADDI, 5, 0, 'h22); // Squashed fetch
		emitImm(OP_ADDI, 6, 0, 'h33);
		emitImm(OP_ADDI, 7, 0, 'h44);
		emitImm(OP_BNE, 2, 1, 3); // Not taken
		emitImm(OP_ADDI, 8, 0, 'h55);
		emitImm(OP_ADDI, 9, 0, 'h66);
		emitImm(OP_BEQ, 3, 1, 5); // Not taken
		emitImm(OP_ADDI, 10, 0, 1);
		emitImm(OP_ADDI, 11, 0, 2);
		emitImm(OP_ADDI, 12, 0, 3);
		emitImm(OP_ADDI, 13, 13, 1); // Word 15, loop head
		emitImm(OP_ADDI, 12, 12, -1);
		emitImm(OP_BNE, 0, 12, -2); // Backward to word 15
		emitImm(OP_ADDI, 14, 14, 2);
		emitImm(OP_ADDI, 15, 0, 'h77);
		emitImm(OP_BNE, 3, 1, 3); // Word 20, taken to word 23
		emitImm(OP_ADDI, 16, 0, 'h88);
		emitImm(OP_ADDI, 17, 0, 'h99);
		emitImm(OP_ADDI, 18, 0, 'haa);
		appendHalt();
		runAndCheck("branch");
	endtask

	task automatic testJump();
		prog.delete();
		emitImm(OP_ADDI, 1, 0, 1);
		emitJump(4);
		emitImm(OP_ADDI, 2, 0, 'hbad); // Behind the J
		emitImm(OP_ADDI, 3, 0, 'hbad);
		emitImm(OP_ADDI, 4, 1, 'h40);
		emitJump(9);
		emitImm(OP_ADDI, 5, 0, 'hbad);
		emitImm(OP_ADDI, 10, 0, 5); // Word 7, reached backward
		emitJump(12);
		emitImm(OP_ADDI, 11, 4, 6);
		emitJump(7);
		emitImm(OP_ADDI, 6, 0, 'hbad);
		emitImm(OP_ADDI, 12, 11, 1);
		appendHalt();
		runAndCheck("jump");
	endtask

	task automatic testRegZero();
		prog.delete();
		emitImm(OP_ADDI, 0, 0, 'h123);
		emitImm(OP_ADDI, 1, 0, 'h5a);
		prog.push_back('0);
		emitReg(FN_ADD, 0, 1, 1);
		prog.push_back('0);
		prog.push_back('0);
		emitReg(FN_ADD, 2, 0, 0);
		emitImm(OP_ORI, 3, 0, 'hffff);
		emitImm(OP_ADDI, 0, 1, 3);
		emitReg(FN_ADD, 4, 0, 1); // r0 in MEM must not forward
		prog.push_back({6'h3f, 5'd1, 5'd5, 16'h0042}); // Unsupported opcode
		prog.push_back({6'd0, 5'd1, 5'd1, 5'd6, 5'd2, 6'd0}); // Shift, not kept
		emitReg(FN_OR, 7, 0, 4);
		appendHalt();
		runAndCheck("register zero");
	endtask

	initial begin
		rstN = 1'b0;
		imemWrEn = 1'b0;
		imemAddr = '0;
		imemData = '0;
		rngState = 32'h3fd6764c;
		testAluOps();
		testForwarding();
		testMemory();
		testBranches();
		testJump();
		testRegZero();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- files.f
+incdir+verilog
verilog/mipsPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/registerFile.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/mipsPipeline.sv
tests/mipsPipelineTb.sv

//--- Makefile
# Verilator build for the MIPS pipeline testbench
VERILATOR ?= verilator
TOP ?= mipsPipelineTb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS ?=

COMMON = --timing --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON) $(VFLAGS)

# The binary exits nonzero when the testbench stops with $$fatal
sim:
	$(VERILATOR) --binary $(COMMON) $(VFLAGS) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
